// ==== sim.f ====
common/mem_system_pkg.sv
common/cache_bus_if.sv
common/mem_bus_if.sv
cache/cache_way.sv
cache/cache_controller.sv
verilog/main_memory.sv
verilog/mem_system.sv
bench/mem_system_checker.sv
bench/mem_system_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= mem_system_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "ERRORS FOUND" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/mem_system_tb.sv ====
`timescale 1ns/1ps

module mem_system_tb;

	localparam int total_requests = 4 + 4 + 5 + 300 + 2;
	localparam int cycle_limit = total_requests * 14 + 100;   // Worst case is a dirty miss

	logic clk;
	logic rst_n;
	logic [mem_system_pkg::addr_w-1:0] addr;
	logic [mem_system_pkg::data_w-1:0] data_in;
	logic rd;
	logic wr;
	logic [mem_system_pkg::data_w-1:0] data_out;
	logic done;
	logic stall;
	logic cache_hit;
	logic err;

	// Reference model
	logic [15:0] ref_mem [mem_system_pkg::mem_words];
	logic [7:0] ref_tag [2][mem_system_pkg::num_sets];
	logic ref_valid [2][mem_system_pkg::num_sets];
	logic ref_dirty [2][mem_system_pkg::num_sets];
	logic ref_victim;

	logic [31:0] lcg_state;
	int cycle_count = 0;
	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int test_err_base;
	int last_lat;
	logic last_hit;
	logic [15:0] last_data;
	string cur_test;

	mem_system dut_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.addr      (addr),
		.data_in   (data_in),
		.rd        (rd),
		.wr        (wr),
		.data_out  (data_out),
		.done      (done),
		.stall     (stall),
		.cache_hit (cache_hit),
		.err       (err)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("Timeout: run still going after %0d cycles", cycle_limit);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Error %s %s: expected %0h actual %0h", cur_test, what, exp, act);
		end
	endtask

	task automatic open_test(input string name);
		cur_test = name;
		test_err_base = errors;
	endtask

	task automatic close_test();
		tests_run++;
		if (errors == test_err_base) begin
			$display("Test %s passed", cur_test);
		end else begin
			tests_failed++;
			$display("Test %s failed with %0d errors", cur_test, errors - test_err_base);
		end
	endtask

	// Updates the model for one accepted request
	task automatic predict(input logic is_wr, input logic [15:0] a, input logic [15:0] d,
		output logic exp_hit, output int exp_lat);
		logic [4:0] idx;
		logic [7:0] tg;
		int w;
		idx = a[7:3];
		tg = a[15:8];
		ref_victim = ~ref_victim;
		w = -1;
		for (int i = 0; i < 2; i++) begin
			if (ref_valid[i][idx] && ref_tag[i][idx] == tg) begin
				w = i;
			end
		end
		exp_hit = (w >= 0);
		exp_lat = 0;
		if (w < 0) begin
			w = !ref_valid[0][idx] ? 0 : !ref_valid[1][idx] ? 1 : int'(ref_victim);
			exp_lat = (ref_valid[w][idx] && ref_dirty[w][idx]) ? 12 : 8;
			ref_tag[w][idx] = tg;
			ref_valid[w][idx] = 1'b1;
			ref_dirty[w][idx] = 1'b0;
		end
		if (is_wr) begin
			ref_dirty[w][idx] = 1'b1;
			ref_mem[a[15:1]] = d;
		end
	endtask

	task automatic access(input logic is_wr, input logic [15:0] a, input logic [15:0] d);
		logic exp_hit;
		int exp_lat;
		predict(is_wr, a, d, exp_hit, exp_lat);
		@(negedge clk);
		addr = a;
		data_in = d;
		rd = ~is_wr;
		wr = is_wr;
		last_lat = 0;
		#10;
		if (!done && !stall) begin
			errors++;
			$display("%s: request to %h got neither done nor stall", cur_test, a);
		end
		while (!done) begin
			@(negedge clk);
			rd = 1'b0;
			wr = 1'b0;
			addr = ~a;       // Stalled DUT must work from its latched copy
			data_in = ~d;
			last_lat++;
			#10;
		end
		last_hit = cache_hit;
		last_data = data_out;
		compare("latency", exp_lat, last_lat);
		compare("cache_hit", exp_hit, last_hit);
		if (!is_wr) begin
			compare("read data", ref_mem[a[15:1]], last_data);
		end
		@(negedge clk);
		rd = 1'b0;
		wr = 1'b0;
	endtask

	initial begin
		logic [31:0] r;
		logic [15:0] a;
		logic [7:0] tg;
		clk = 1'b0;
		rst_n = 1'b0;
		addr = '0;
		data_in = '0;
		rd = 1'b0;
		wr = 1'b0;
		lcg_state = 32'd79662;
		ref_victim = 1'b0;
		for (int i = 0; i < mem_system_pkg::mem_words; i++) begin
			ref_mem[i] = 16'(i);   // Memory starts at its word address
		end
		for (int s = 0; s < mem_system_pkg::num_sets; s++) begin
			ref_valid[0][s] = 1'b0;
			ref_valid[1][s] = 1'b0;
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		open_test("read_after_reset");
		for (int i = 0; i < 4; i++) begin
			a = {8'h40, 5'(10 + i), 2'(i), 1'b0};
			access(1'b0, a, 16'h0);
			compare("miss latency", 8, last_lat);
			compare("word address", {1'b0, a[15:1]}, last_data);
		end
		close_test();

		open_test("write_then_read");
		a = {8'h50, 5'd16, 2'd1, 1'b0};
		access(1'b1, a, 16'h1234);
		access(1'b0, a, 16'h0);
		compare("written data", 16'h1234, last_data);
		access(1'b1, a, 16'hbeef);
		access(1'b0, a, 16'h0);
		compare("rewritten data", 16'hbeef, last_data);
		compare("hit on read", 1, last_hit);
		close_test();

		open_test("dirty_eviction");
		access(1'b1, {8'h60, 5'd20, 3'd0}, 16'haaaa);
		access(1'b1, {8'h61, 5'd20, 3'd0}, 16'h5555);
		access(1'b0, {8'h62, 5'd20, 3'd0}, 16'h0);   // Both ways dirty now
		compare("writeback latency", 12, last_lat);
		access(1'b0, {8'h60, 5'd20, 3'd0}, 16'h0);
		access(1'b0, {8'h61, 5'd20, 3'd0}, 16'h0);
		compare("evicted data", 16'h5555, last_data);
		close_test();

		open_test("random_mix");
		repeat (300) begin
			r = next_random();
			tg = {6'd0, r[17:16]} * 8'd37;
			a = {tg, 3'd0, r[21:20], r[25:24], 1'b0};   // 4 tags over sets 0 to 3
			access(r[30], a, 16'(next_random() >> 16));
		end
		close_test();

		open_test("illegal_request");
		@(negedge clk);
		addr = {8'h50, 5'd16, 2'd1, 1'b0};
		data_in = 16'hdead;
		rd = 1'b1;
		wr = 1'b1;
		#10;
		compare("err", 1, err);
		compare("done on illegal", 0, done);
		compare("stall on illegal", 0, stall);
		@(negedge clk);
		rd = 1'b0;
		wr = 1'b0;
		#10;
		compare("err after release", 0, err);
		access(1'b0, {8'h50, 5'd16, 2'd1, 1'b0}, 16'h0);
		compare("data after illegal", 16'hbeef, last_data);
		close_test();

		$display("Tests run %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// ==== bench/mem_system_checker.sv ====
`timescale 1ns/1ps

module mem_system_checker (
	input logic clk,
	input logic rst_n,
	input logic rd,
	input logic wr,
	input logic done,
	input logic stall,
	input logic err
);

	logic [3:0] stall_len;   // Consecutive stall cycles so far

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			stall_len <= '0;
		end else begin
			stall_len <= stall ? stall_len + 4'd1 : 4'd0;
		end
	end

	done_stall_excl: assert property (@(posedge clk) disable iff (!rst_n) !(done && stall))
		else $error("done and stall high in the same cycle");
	done_ends_stall: assert property (@(posedge clk) disable iff (!rst_n) $fell(stall) |-> done)
		else $error("stall dropped without done");
	done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) $fell(stall) |=> !done)
		else $error("done held longer than one cycle after a stall");
	stall_bound: assert property (@(posedge clk) disable iff (!rst_n) stall_len <= 4'd12)
		else $error("stall held longer than 12 cycles");
	err_on_both: assert property (@(posedge clk) disable iff (!rst_n) $rose(err) |-> (rd && wr))
		else $error("err rose without rd and wr together");

endmodule

bind mem_system mem_system_checker checker_i (
	.clk   (clk),
	.rst_n (rst_n),
	.rd    (rd),
	.wr    (wr),
	.done  (done),
	.stall (stall),
	.err   (err)
);

// ==== verilog/mem_system.sv ====
`timescale 1ns/1ps

module mem_system (
	input  logic clk,
	input  logic rst_n,
	input  logic [mem_system_pkg::addr_w-1:0] addr,
	input  logic [mem_system_pkg::data_w-1:0] data_in,
	input  logic rd,
	input  logic wr,
	output logic [mem_system_pkg::data_w-1:0] data_out,
	output logic done,
	output logic stall,
	output logic cache_hit,
	output logic err
);

	cache_bus_if cbus ();
	mem_bus_if mbus ();

	cache_controller ctrl_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.addr      (addr),
		.data_in   (data_in),
		.rd        (rd),
		.wr        (wr),
		.data_out  (data_out),
		.done      (done),
		.stall     (stall),
		.cache_hit (cache_hit),
		.err       (err),
		.cbus      (cbus),
		.mbus      (mbus)
	);

	cache_way #(.way_id(0)) way0_i (.clk(clk), .rst_n(rst_n), .bus(cbus));
	cache_way #(.way_id(1)) way1_i (.clk(clk), .rst_n(rst_n), .bus(cbus));

	main_memory mem_i (
		.clk   (clk),
		.rst_n (rst_n),
		.bus   (mbus)
	);

endmodule

// ==== verilog/main_memory.sv ====
`timescale 1ns/1ps

module main_memory (
	input logic clk,
	input logic rst_n,
	mem_bus_if.mem bus
);

	// One bank per word position in a line
	logic [mem_system_pkg::data_w-1:0] bank [mem_system_pkg::words_per_line]
		[mem_system_pkg::mem_words / mem_system_pkg::words_per_line];
	logic [1:0] bank_sel;
	logic [mem_system_pkg::addr_w-4:0] row;
	logic [mem_system_pkg::mem_latency-1:0] rd_pipe;
	logic [mem_system_pkg::data_w-1:0] data_pipe [mem_system_pkg::mem_latency];

	assign bank_sel = bus.addr[2:1];                        // Word bits 1..0
	assign row = bus.addr[mem_system_pkg::addr_w-1:3];

	// Each word starts out holding its own word address
	initial begin
		for (int i = 0; i < mem_system_pkg::mem_words; i++) begin
			bank[i % mem_system_pkg::words_per_line][i / mem_system_pkg::words_per_line] =
				mem_system_pkg::data_w'(i);
		end
	end

	always @(posedge clk) begin
		if (bus.wr) begin
			bank[bank_sel][row] <= bus.wdata;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_pipe <= '0;
		end else begin
			rd_pipe <= {rd_pipe[mem_system_pkg::mem_latency-2:0], bus.rd};
		end
	end

	always_ff @(posedge clk) begin
		data_pipe[0] <= bank[bank_sel][row];
		for (int s = 1; s < mem_system_pkg::mem_latency; s++) begin
			data_pipe[s] <= data_pipe[s-1];   // Several reads in flight
		end
	end

	assign bus.rvalid = rd_pipe[mem_system_pkg::mem_latency-1];
	assign bus.rdata = data_pipe[mem_system_pkg::mem_latency-1];

endmodule

// ==== cache/cache_controller.sv ====
`timescale 1ns/1ps

module cache_controller (
	input  logic clk,
	input  logic rst_n,
	input  logic [mem_system_pkg::addr_w-1:0] addr,
	input  logic [mem_system_pkg::data_w-1:0] data_in,
	input  logic rd,
	input  logic wr,
	output logic [mem_system_pkg::data_w-1:0] data_out,
	output logic done,
	output logic stall,
	output logic cache_hit,
	output logic err,
	cache_bus_if.ctrl cbus,
	mem_bus_if.ctrl mbus
);

	mem_system_pkg::ctrl_state_e state, next_state;
	logic [mem_system_pkg::addr_w-1:0] req_addr;
	logic [mem_system_pkg::data_w-1:0] req_data;
	logic [mem_system_pkg::index_w-1:0] req_index;
	logic [mem_system_pkg::tag_w-1:0] req_tag;
	logic req_wr;
	logic victim;
	logic way_sel;       // Way being written back or filled
	logic alloc_way;
	logic accept;
	logic out_way;
	logic [1:0] way_onehot;
	logic [1:0] step;    // Word of the line for the current state

	function automatic logic [mem_system_pkg::offset_w-1:0] word_off(
		input logic [mem_system_pkg::offset_w-2:0] w
	);
		return {w, 1'b0};
	endfunction

	assign req_index = req_addr[mem_system_pkg::offset_w +: mem_system_pkg::index_w];
	assign req_tag = req_addr[mem_system_pkg::addr_w-1 -: mem_system_pkg::tag_w];
	assign accept = (state == mem_system_pkg::st_idle) & (rd ^ wr);
	assign way_onehot = way_sel ? 2'b10 : 2'b01;

	// Invalid way first, then the victim bit
	assign alloc_way = ~cbus.valid[0] ? 1'b0 : ~cbus.valid[1] ? 1'b1 : victim;

	assign out_way = (state == mem_system_pkg::st_idle) ? cbus.hit[1] : way_sel;
	assign data_out = cbus.rdata[out_way];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= mem_system_pkg::st_idle;
			victim <= 1'b0;
			way_sel <= 1'b0;
			req_wr <= 1'b0;
		end else begin
			state <= next_state;
			if (accept) begin
				victim <= ~victim;   // Flips on every accepted request
				req_wr <= wr;
			end
			if (state == mem_system_pkg::st_alloc) begin
				way_sel <= alloc_way;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			req_addr <= addr;
			req_data <= data_in;
		end
	end

	always_comb begin
		case (state)
			mem_system_pkg::st_wb1, mem_system_pkg::st_req1, mem_system_pkg::st_fill1: step = 2'd1;
			mem_system_pkg::st_wb2, mem_system_pkg::st_fill2: step = 2'd2;
			mem_system_pkg::st_wb3, mem_system_pkg::st_fill3: step = 2'd3;
			default: step = 2'd0;
		endcase
	end

	always_comb begin
		next_state = state;
		done = 1'b0;
		stall = 1'b0;
		cache_hit = 1'b0;
		err = 1'b0;
		cbus.enable = 2'b00;
		cbus.index = req_index;
		cbus.offset = req_addr[mem_system_pkg::offset_w-1:0];
		cbus.tag = req_tag;
		cbus.comp = 1'b0;
		cbus.write = 1'b0;
		cbus.wdata = req_data;
		cbus.valid_in = 1'b0;
		mbus.addr = {req_tag, req_index, word_off(step)};
		mbus.wdata = cbus.rdata[way_sel];
		mbus.wr = 1'b0;
		mbus.rd = 1'b0;

		case (state)
			mem_system_pkg::st_idle: begin
				err = rd & wr;   // Both strobes, request dropped
				cbus.enable = accept ? 2'b11 : 2'b00;
				cbus.index = addr[mem_system_pkg::offset_w +: mem_system_pkg::index_w];
				cbus.offset = addr[mem_system_pkg::offset_w-1:0];
				cbus.tag = addr[mem_system_pkg::addr_w-1 -: mem_system_pkg::tag_w];
				cbus.comp = 1'b1;
				cbus.write = wr;
				cbus.wdata = data_in;
				done = cbus.hit[0] | cbus.hit[1];
				cache_hit = done;
				stall = accept & ~done;
				if (stall) begin
					next_state = mem_system_pkg::st_alloc;
				end
			end
			mem_system_pkg::st_alloc: begin
				stall = 1'b1;
				cbus.enable = 2'b11;   // Status only, no write
				next_state = (cbus.valid[alloc_way] & cbus.dirty[alloc_way]) ?
					mem_system_pkg::st_wb0 : mem_system_pkg::st_req0;
			end
			mem_system_pkg::st_wb0, mem_system_pkg::st_wb1,
			mem_system_pkg::st_wb2, mem_system_pkg::st_wb3: begin
				stall = 1'b1;
				cbus.enable = way_onehot;
				cbus.offset = word_off(step);
				mbus.addr = {cbus.tag_out[way_sel], req_index, word_off(step)};
				mbus.wr = 1'b1;
				next_state = mem_system_pkg::ctrl_state_e'(state + 4'd1);
			end
			mem_system_pkg::st_req0, mem_system_pkg::st_req1: begin
				stall = 1'b1;
				mbus.rd = 1'b1;
				next_state = mem_system_pkg::ctrl_state_e'(state + 4'd1);
			end
			mem_system_pkg::st_fill0, mem_system_pkg::st_fill1,
			mem_system_pkg::st_fill2, mem_system_pkg::st_fill3: begin
				stall = 1'b1;
				cbus.enable = way_onehot;
				cbus.offset = word_off(step);
				cbus.write = mbus.rvalid;
				cbus.wdata = mbus.rdata;
				cbus.valid_in = 1'b1;
				// Last two reads overlap the first two fills
				mbus.rd = (state == mem_system_pkg::st_fill0) | (state == mem_system_pkg::st_fill1);
				mbus.addr = {req_tag, req_index, word_off(step + 2'd2)};
				next_state = mem_system_pkg::ctrl_state_e'(state + 4'd1);
			end
			mem_system_pkg::st_done: begin
				done = 1'b1;
				cbus.enable = way_onehot;
				cbus.comp = 1'b1;      // Applies a pending write, marks dirty
				cbus.write = req_wr;
				next_state = mem_system_pkg::st_idle;
			end
			default: begin
				err = 1'b1;
				next_state = mem_system_pkg::st_idle;
			end
		endcase
	end

endmodule

// ==== cache/cache_way.sv ====
`timescale 1ns/1ps

module cache_way #(
	parameter int way_id = 0
) (
	input logic clk,
	input logic rst_n,
	cache_bus_if.way bus
);

	logic [mem_system_pkg::tag_w-1:0] tag_mem [mem_system_pkg::num_sets];
	logic [mem_system_pkg::data_w-1:0] data_mem
		[mem_system_pkg::num_sets][mem_system_pkg::words_per_line];
	logic [mem_system_pkg::num_sets-1:0] valid_mem;
	logic [mem_system_pkg::num_sets-1:0] dirty_mem;
	logic [mem_system_pkg::offset_w-2:0] word;
	logic sel;
	logic tag_match;
	logic hit;
	logic wr_en;

	assign word = bus.offset[mem_system_pkg::offset_w-1:1];   // Drop the byte bit
	assign sel = bus.enable[way_id];
	assign tag_match = (tag_mem[bus.index] == bus.tag);
	assign hit = sel & bus.comp & valid_mem[bus.index] & tag_match;

	// A compare write lands only on a hit, a direct write always lands
	assign wr_en = sel & bus.write & (hit | ~bus.comp);

	// Status is visible whether or not the way is enabled
	assign bus.hit[way_id] = hit;
	assign bus.valid[way_id] = valid_mem[bus.index];
	assign bus.dirty[way_id] = dirty_mem[bus.index];
	assign bus.rdata[way_id] = data_mem[bus.index][word];
	assign bus.tag_out[way_id] = tag_mem[bus.index];   // Victim address for writeback

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_mem <= '0;
			dirty_mem <= '0;
		end else if (wr_en) begin
			if (bus.comp) begin
				dirty_mem[bus.index] <= 1'b1;          // Requester write
			end else begin
				valid_mem[bus.index] <= bus.valid_in;  // Line fill
				dirty_mem[bus.index] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			data_mem[bus.index][word] <= bus.wdata;
			if (!bus.comp) begin
				tag_mem[bus.index] <= bus.tag;
			end
		end
	end

endmodule

// ==== common/mem_bus_if.sv ====
`timescale 1ns/1ps

interface mem_bus_if;

	logic [mem_system_pkg::addr_w-1:0] addr;   // Byte address, word aligned
	logic [mem_system_pkg::data_w-1:0] wdata;
	logic wr;
	logic rd;
	logic [mem_system_pkg::data_w-1:0] rdata;
	logic rvalid;                              // Two cycles after rd

	modport ctrl (
		output addr, wdata, wr, rd,
		input  rdata, rvalid
	);

	modport mem (
		input  addr, wdata, wr, rd,
		output rdata, rvalid
	);

endinterface

// ==== common/cache_bus_if.sv ====
`timescale 1ns/1ps

interface cache_bus_if;

	// From the controller, shared by both ways
	logic [1:0] enable;                                  // One bit per way
	logic [mem_system_pkg::index_w-1:0] index;
	logic [mem_system_pkg::offset_w-1:0] offset;
	logic [mem_system_pkg::tag_w-1:0] tag;
	logic comp;                                          // Tag compare access
	logic write;
	logic [mem_system_pkg::data_w-1:0] wdata;
	logic valid_in;

	// Each way drives its own bit or lane
	wire [1:0] hit;
	wire [1:0] valid;
	wire [1:0] dirty;
	wire [mem_system_pkg::data_w-1:0] rdata [2];
	wire [mem_system_pkg::tag_w-1:0] tag_out [2];

	modport ctrl (
		output enable, index, offset, tag, comp, write, wdata, valid_in,
		input  hit, valid, dirty, rdata, tag_out
	);

	modport way (
		input  enable, index, offset, tag, comp, write, wdata, valid_in,
		output hit, valid, dirty, rdata, tag_out
	);

endinterface

// ==== common/mem_system_pkg.sv ====
package mem_system_pkg;

	// Requester side
	localparam int addr_w = 16;          // Byte address
	localparam int data_w = 16;          // One word

	// Cache geometry
	localparam int offset_w = 3;         // Byte offset in a line
	localparam int index_w = 5;          // Address bits 7..3
	localparam int tag_w = 8;            // Address bits 15..8
	localparam int words_per_line = 4;   // Words at offsets 0, 2, 4, 6
	localparam int num_sets = 32;

	// Backing store
	localparam int mem_latency = 2;      // Read request to data, in cycles
	localparam int mem_words = 32768;

	// Order matters, the controller steps through these one by one
	typedef enum logic [3:0] {
		st_idle,
		st_alloc,
		st_wb0,
		st_wb1,
		st_wb2,
		st_wb3,
		st_req0,
		st_req1,
		st_fill0,
		st_fill1,
		st_fill2,
		st_fill3,
		st_done
	} ctrl_state_e;

endpackage
